// File: cpuPkg.sv
package cpuPkg;

	// Datapath widths
	localparam int dataWidth = 16;
	localparam int instrWidth = 32;
	localparam int regAddrWidth = 5;   // 32 registers
	localparam int pcWidth = 8;        // Instruction memory index
	localparam int dmemDepth = 256;    // Halfwords
	localparam int imemDepth = 256;    // Instruction words

	// Host bus
	localparam int axiAddrWidth = 12;
	localparam int axiDataWidth = 32;
	localparam logic [axiAddrWidth-1:0] ctrlRegAddr = 12'h400;  // Run bit in data bit 0
	localparam logic [axiAddrWidth-1:0] regReadBase = 12'h800;  // Register n at base + 4n

	typedef logic [dataWidth-1:0] dataT;
	typedef logic [pcWidth-1:0] pcT;

	// Instruction bits 31:26
	typedef enum logic [5:0] {
		opRType = 6'b000000,
		opJmp   = 6'b000010,
		opBeq   = 6'b000100,
		opBne   = 6'b000101,
		opAddi  = 6'b001000,
		opLw    = 6'b100011,
		opSw    = 6'b101011
	} opcodeE;

	// Instruction bits 5:0 of R-type
	typedef enum logic [5:0] {
		fnSll  = 6'b000000,
		fnSrl  = 6'b000010,
		fnAdd  = 6'b100000,
		fnSub  = 6'b100010,
		fnAnd  = 6'b100100,
		fnOr   = 6'b100101,
		fnXor  = 6'b100110,
		fnNor  = 6'b100111,
		fnNand = 6'b101000,
		fnXnor = 6'b101010
	} functE;

	typedef enum logic [3:0] {
		aluAdd, aluSub, aluAnd, aluOr, aluXor,
		aluNor, aluNand, aluXnor, aluSll, aluSrl
	} aluOpE;

	typedef enum logic [1:0] {brNone, brEq, brNe} branchE;

	typedef struct packed {
		logic   regWrite;
		logic   regDst;     // Destination is rd rather than rt
		logic   aluSrcImm;  // Operand B from the immediate
		logic   memWrite;
		logic   memToReg;
		logic   jump;
		branchE branch;
		aluOpE  aluOp;
	} ctrlT;

endpackage

// File: hostIf.sv
`timescale 1ns/1ps

interface hostIf;
	import cpuPkg::*;

	// Program load port
	logic imemWe;
	pcT imemAddr;
	logic [instrWidth-1:0] imemData;

	logic run;  // Core runs while set

	// Register readback
	logic [regAddrWidth-1:0] dbgAddr;
	dataT dbgData;

	modport bridge (output imemWe, imemAddr, imemData, run, dbgAddr, input dbgData);

	modport fetch (input imemWe, imemAddr, imemData, run);

	modport regs (input run, dbgAddr, output dbgData);

endinterface

// File: hostBridge.sv
`timescale 1ns/1ps

module hostBridge (
	input  logic clk,
	input  logic reset,
	input  logic [cpuPkg::axiAddrWidth-1:0] awaddr,
	input  logic awvalid,
	output logic awready,
	input  logic [cpuPkg::axiDataWidth-1:0] wdata,
	input  logic wvalid,
	output logic wready,
	output logic bvalid,
	input  logic bready,
	input  logic [cpuPkg::axiAddrWidth-1:0] araddr,
	input  logic arvalid,
	output logic arready,
	output logic [cpuPkg::axiDataWidth-1:0] rdata,
	output logic rvalid,
	input  logic rready,
	hostIf.bridge host
);
	import cpuPkg::*;

	logic wrAccept;
	logic rdAccept;
	logic inRegWindow;

	// Address and data are taken only as a pair
	assign wrAccept = awvalid && wvalid && !bvalid;
	assign awready = wrAccept;
	assign wready = wrAccept;

	assign rdAccept = arvalid && !rvalid;
	assign arready = rdAccept;

	// Instruction memory occupies everything below the control register
	assign host.imemWe = wrAccept && (awaddr < ctrlRegAddr);
	assign host.imemAddr = awaddr[pcWidth+1:2];  // Word index
	assign host.imemData = wdata;

	// 32 registers of 4 bytes span 128 bytes above the base
	assign inRegWindow = (araddr[axiAddrWidth-1:regAddrWidth+2] ==
		regReadBase[axiAddrWidth-1:regAddrWidth+2]);
	assign host.dbgAddr = araddr[regAddrWidth+1:2];

	always_ff @(posedge clk) begin
		if (reset) begin
			host.run <= 1'b0;
		end else if (wrAccept && awaddr == ctrlRegAddr) begin
			host.run <= wdata[0];
		end
	end

	// Write response
	always_ff @(posedge clk) begin
		if (reset) begin
			bvalid <= 1'b0;
		end else if (wrAccept) begin
			bvalid <= 1'b1;
		end else if (bready) begin
			bvalid <= 1'b0;
		end
	end

	// Read response
	always_ff @(posedge clk) begin
		if (reset) begin
			rvalid <= 1'b0;
		end else if (rdAccept) begin
			rvalid <= 1'b1;
		end else if (rready) begin
			rvalid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (rdAccept) begin
			if (inRegWindow) begin
				rdata <= {{(axiDataWidth-dataWidth){1'b0}}, host.dbgData};
			end else begin
				rdata <= '0;  // Unmapped reads return zero
			end
		end
	end

endmodule

// File: fetchUnit.sv
`timescale 1ns/1ps

module fetchUnit (
	input  logic clk,
	input  logic reset,
	hostIf.fetch host,
	input  cpuPkg::ctrlT ctrl,
	input  logic zero,
	output logic [cpuPkg::instrWidth-1:0] instr
);
	import cpuPkg::*;

	logic [instrWidth-1:0] imem [imemDepth];
	pcT pc;
	pcT pcPlusOne;
	pcT branchTarget;
	pcT pcNext;
	logic branchTaken;

	// Host loads the program word by word
	always_ff @(posedge clk) begin
		if (host.imemWe) begin
			imem[host.imemAddr] <= host.imemData;
		end
	end

	assign instr = imem[pc];  // Asynchronous fetch

	assign pcPlusOne = pc + pcT'(1);

	// The 16-bit offset is sign-extended, but only its low bits
	// matter once the sum wraps to the PC width
	assign branchTarget = pcPlusOne + instr[pcWidth-1:0];

	always_comb begin
		case (ctrl.branch)
			brEq:    branchTaken = zero;
			brNe:    branchTaken = !zero;
			default: branchTaken = 1'b0;
		endcase
	end

	always_comb begin
		if (ctrl.jump) begin
			pcNext = instr[pcWidth-1:0];  // Low jump-field bits
		end else if (branchTaken) begin
			pcNext = branchTarget;
		end else begin
			pcNext = pcPlusOne;
		end
	end

	// A cleared run bit parks the PC at the start of the program
	always_ff @(posedge clk) begin
		if (reset || !host.run) begin
			pc <= '0;
		end else begin
			pc <= pcNext;
		end
	end

endmodule

// File: controlDecode.sv
`timescale 1ns/1ps

module controlDecode (
	input  cpuPkg::opcodeE opcode,
	input  cpuPkg::functE funct,
	output cpuPkg::ctrlT ctrl
);
	import cpuPkg::*;

	always_comb begin
		// Safe defaults, no write and no branch
		ctrl.regWrite = 1'b0;
		ctrl.regDst = 1'b0;
		ctrl.aluSrcImm = 1'b0;
		ctrl.memWrite = 1'b0;
		ctrl.memToReg = 1'b0;
		ctrl.jump = 1'b0;
		ctrl.branch = brNone;
		ctrl.aluOp = aluAdd;

		case (opcode)
			opRType: begin
				ctrl.regDst = 1'b1;
				ctrl.regWrite = 1'b1;
				case (funct)
					fnAdd:   ctrl.aluOp = aluAdd;
					fnSub:   ctrl.aluOp = aluSub;
					fnAnd:   ctrl.aluOp = aluAnd;
					fnOr:    ctrl.aluOp = aluOr;
					fnXor:   ctrl.aluOp = aluXor;
					fnNor:   ctrl.aluOp = aluNor;
					fnNand:  ctrl.aluOp = aluNand;
					fnXnor:  ctrl.aluOp = aluXnor;
					fnSll:   ctrl.aluOp = aluSll;
					fnSrl:   ctrl.aluOp = aluSrl;
					default: ctrl.regWrite = 1'b0;  // Unknown function
				endcase
			end
			opAddi: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluSrcImm = 1'b1;
			end
			opLw: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluSrcImm = 1'b1;  // Base plus offset
				ctrl.memToReg = 1'b1;
			end
			opSw: begin
				ctrl.aluSrcImm = 1'b1;
				ctrl.memWrite = 1'b1;
			end
			opBeq: begin
				ctrl.branch = brEq;
				ctrl.aluOp = aluSub;  // Equal operands give zero
			end
			opBne: begin
				ctrl.branch = brNe;
				ctrl.aluOp = aluSub;
			end
			opJmp:   ctrl.jump = 1'b1;
			default: ctrl.branch = brNone;
		endcase
	end

endmodule

// File: regFile.sv
`timescale 1ns/1ps

module regFile (
	input  logic clk,
	input  logic reset,
	hostIf.regs host,
	input  logic [cpuPkg::regAddrWidth-1:0] rdAddrA,
	input  logic [cpuPkg::regAddrWidth-1:0] rdAddrB,
	input  logic [cpuPkg::regAddrWidth-1:0] wrAddr,
	input  logic wrEn,
	input  cpuPkg::dataT wrData,
	output cpuPkg::dataT rdDataA,
	output cpuPkg::dataT rdDataB
);
	import cpuPkg::*;

	dataT regs [2**regAddrWidth];

	// Register 0 is never written, so it reads zero
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 2**regAddrWidth; i++) begin
				regs[i] <= '0;
			end
		end else if (wrEn && host.run && wrAddr != '0) begin
			regs[wrAddr] <= wrData;
		end
	end

	assign rdDataA = regs[rdAddrA];
	assign rdDataB = regs[rdAddrB];

	assign host.dbgData = regs[host.dbgAddr];  // Host readback port

endmodule

// File: alu.sv
`timescale 1ns/1ps

module alu (
	input  cpuPkg::aluOpE op,
	input  cpuPkg::dataT a,
	input  cpuPkg::dataT b,
	output cpuPkg::dataT result,
	output logic zero
);
	import cpuPkg::*;

	always_comb begin
		case (op)
			aluAdd:  result = a + b;
			aluSub:  result = a - b;
			aluAnd:  result = a & b;
			aluOr:   result = a | b;
			aluXor:  result = a ^ b;
			aluNor:  result = ~(a | b);
			aluNand: result = ~(a & b);
			aluXnor: result = ~(a ^ b);
			aluSll:  result = a << 1;  // Shifts act on a only
			aluSrl:  result = a >> 1;
			default: result = '0;
		endcase
	end

	// Branch compare
	assign zero = (result == '0);

endmodule

// File: dataMem.sv
`timescale 1ns/1ps

module dataMem (
	input  logic clk,
	input  logic reset,
	hostIf.regs host,
	input  logic [$clog2(cpuPkg::dmemDepth)-1:0] addr,
	input  logic wrEn,
	input  cpuPkg::dataT wrData,
	output cpuPkg::dataT rdData
);
	import cpuPkg::*;

	dataT mem [dmemDepth];

	// Cleared by reset, stores land only while the core runs
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < dmemDepth; i++) begin
				mem[i] <= '0;
			end
		end else if (wrEn && host.run) begin
			mem[addr] <= wrData;
		end
	end

	assign rdData = mem[addr];

endmodule

// File: cpuCore.sv
`timescale 1ns/1ps

module cpuCore (
	input  logic clk,
	input  logic reset,
	input  logic [cpuPkg::axiAddrWidth-1:0] awaddr,
	input  logic awvalid,
	output logic awready,
	input  logic [cpuPkg::axiDataWidth-1:0] wdata,
	input  logic wvalid,
	output logic wready,
	output logic bvalid,
	input  logic bready,
	input  logic [cpuPkg::axiAddrWidth-1:0] araddr,
	input  logic arvalid,
	output logic arready,
	output logic [cpuPkg::axiDataWidth-1:0] rdata,
	output logic rvalid,
	input  logic rready
);
	import cpuPkg::*;

	logic [instrWidth-1:0] instr;
	opcodeE opcode;
	functE funct;
	ctrlT ctrl;
	logic [regAddrWidth-1:0] wrAddr;
	dataT rdDataA;
	dataT rdDataB;
	dataT immVal;
	dataT aluB;
	dataT aluResult;
	dataT memData;
	dataT wrData;
	logic zero;

	hostIf hostBus ();

	hostBridge hostBridge_i (
		.clk(clk), .reset(reset),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wvalid(wvalid), .wready(wready),
		.bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rvalid(rvalid), .rready(rready),
		.host(hostBus.bridge)
	);

	fetchUnit fetchUnit_i (
		.clk(clk), .reset(reset), .host(hostBus.fetch),
		.ctrl(ctrl), .zero(zero), .instr(instr)
	);

	assign opcode = opcodeE'(instr[31:26]);
	assign funct = functE'(instr[5:0]);

	controlDecode controlDecode_i (.opcode(opcode), .funct(funct), .ctrl(ctrl));

	assign wrAddr = ctrl.regDst ? instr[15:11] : instr[20:16];  // rd or rt

	regFile regFile_i (
		.clk(clk), .reset(reset), .host(hostBus.regs),
		.rdAddrA(instr[25:21]), .rdAddrB(instr[20:16]), .wrAddr(wrAddr),
		.wrEn(ctrl.regWrite), .wrData(wrData),
		.rdDataA(rdDataA), .rdDataB(rdDataB)
	);

	// Immediate field already spans the full data width
	assign immVal = instr[dataWidth-1:0];
	assign aluB = ctrl.aluSrcImm ? immVal : rdDataB;

	alu alu_i (.op(ctrl.aluOp), .a(rdDataA), .b(aluB), .result(aluResult), .zero(zero));

	dataMem dataMem_i (
		.clk(clk), .reset(reset), .host(hostBus.regs),
		.addr(aluResult[$clog2(dmemDepth)-1:0]),
		.wrEn(ctrl.memWrite), .wrData(rdDataB), .rdData(memData)
	);

	assign wrData = ctrl.memToReg ? memData : aluResult;  // Writeback select

endmodule

// File: cpuCore_properties.sv
`timescale 1ns/1ps

module cpuCore_properties (
	input logic clk,
	input logic reset,
	input logic awready,
	input logic wready,
	input logic bvalid,
	input logic bready,
	input logic [cpuPkg::axiAddrWidth-1:0] araddr,
	input logic arvalid,
	input logic arready,
	input logic [cpuPkg::axiDataWidth-1:0] rdata,
	input logic rvalid,
	input logic rready
);
	import cpuPkg::*;

	int failCount = 0;  // Summed into the final count

	bHeld: assert property (@(posedge clk) disable iff (reset)
		bvalid && !bready |=> bvalid)
	else begin
		failCount++;
		$error("bvalid dropped before the host raised bready");
	end

	// Read data must not change while it waits
	rHeld: assert property (@(posedge clk) disable iff (reset)
		rvalid && !rready |=> rvalid && $stable(rdata))
	else begin
		failCount++;
		$error("rvalid dropped or rdata changed before the host raised rready");
	end

	noWriteWhileResp: assert property (@(posedge clk) disable iff (reset)
		bvalid |-> !awready)
	else begin
		failCount++;
		$error("awready was high while a write response was pending");
	end

	// Address and data are only ever taken together
	pairedReady: assert property (@(posedge clk) disable iff (reset)
		awready == wready)
	else begin
		failCount++;
		$error("awready and wready differed");
	end

	readReady: assert property (@(posedge clk) disable iff (reset)
		arvalid && !rvalid |-> arready)
	else begin
		failCount++;
		$error("arready stayed low with no read data pending");
	end

	regZeroReadback: assert property (@(posedge clk) disable iff (reset)
		arvalid && arready && araddr == regReadBase |=> rdata == '0)
	else begin
		failCount++;
		$error("register 0 read back as nonzero");
	end

endmodule

bind cpuCore cpuCore_properties cpuCore_properties_i (.*);

// File: tb_cpuCore.sv
`timescale 1ns/1ps

module tb_cpuCore;
	import cpuPkg::*;

	// Five tests of at most 700 cycles each, plus reset and margin
	localparam int testCycles = 700;
	localparam int timeoutCycles = 5 * testCycles + 500;

	logic clk = 1'b0;
	logic reset;
	logic [axiAddrWidth-1:0] awaddr;
	logic awvalid;
	logic awready;
	logic [axiDataWidth-1:0] wdata;
	logic wvalid;
	logic wready;
	logic bvalid;
	logic bready;
	logic [axiAddrWidth-1:0] araddr;
	logic arvalid;
	logic arready;
	logic [axiDataWidth-1:0] rdata;
	logic rvalid;
	logic rready;

	int cycles = 0;
	int errors = 0;
	int checks = 0;
	int testsRun = 0;
	int errorsAtStart;
	int totalErrors;
	logic [31:0] seed = 32'hf3f9_b8eb;
	logic [instrWidth-1:0] prog [$];
	dataT opA;
	dataT opB;
	dataT expected [10];
	functE functs [10];

	cpuCore cpuCore_i (.*);

	always #50 clk = ~clk;

	always @(posedge clk) begin
		cycles++;
		if (cycles >= timeoutCycles) begin
			$display("Timeout: the run did not finish within %0d cycles", timeoutCycles);
			$display("Errors found");
			$finish;
		end
	end

	function automatic logic [31:0] nextRandom(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic logic [31:0] encodeR(input functE fn, input int rs, input int rt, input int rd);
		return {opRType, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
	endfunction

	function automatic logic [31:0] encodeI(input opcodeE op, input int rs, input int rt,
		input logic [15:0] imm);
		return {op, 5'(rs), 5'(rt), imm};
	endfunction

	function automatic logic [31:0] encodeJ(input int target);
		return {opJmp, 26'(target)};
	endfunction

	function automatic logic [axiAddrWidth-1:0] readbackAddr(input int idx);
		return regReadBase + 12'(4 * idx);
	endfunction

	// Request stays up through the first response cycle, when awready
	// must already be low, and bready waits a cycle more
	task automatic axiWrite(input logic [axiAddrWidth-1:0] addr, input logic [31:0] data);
		@(negedge clk);
		awaddr = addr;
		wdata = data;
		awvalid = 1'b1;
		wvalid = 1'b1;
		bready = 1'b0;
		@(negedge clk);
		while (!bvalid) begin
			@(negedge clk);
		end
		@(negedge clk);
		awvalid = 1'b0;
		wvalid = 1'b0;
		bready = 1'b1;
		@(negedge clk);
		bready = 1'b0;
	endtask

	task automatic axiRead(input logic [axiAddrWidth-1:0] addr, output logic [31:0] data);
		@(negedge clk);
		araddr = addr;
		arvalid = 1'b1;
		@(negedge clk);
		while (!rvalid) begin
			@(negedge clk);
		end
		arvalid = 1'b0;
		@(negedge clk);
		data = rdata;  // Held while rready is low
		rready = 1'b1;
		@(negedge clk);
		rready = 1'b0;
	endtask

	task automatic checkRead(input logic [axiAddrWidth-1:0] addr, input logic [31:0] exp);
		logic [31:0] got;
		axiRead(addr, got);
		checks++;
		assert (got == exp) else begin
			$display("FAIL %0t: read at %h returned %h, expected %h", $time, addr, got, exp);
			errors++;
		end
	endtask

	task automatic loadProgram();
		foreach (prog[i]) begin
			axiWrite(12'(4 * i), prog[i]);
		end
	endtask

	// Every program ends in a jump to itself, so 64 cycles is plenty
	task automatic runProgram();
		axiWrite(ctrlRegAddr, 32'd1);
		repeat (64) @(negedge clk);
		axiWrite(ctrlRegAddr, 32'd0);
	endtask

	task automatic startTest();
		@(negedge clk);
		reset = 1'b1;
		repeat (10) @(negedge clk);
		reset = 1'b0;
		errorsAtStart = errors;
	endtask

	task automatic reportTest(input string name);
		testsRun++;
		$display("%s: %s", name, (errors == errorsAtStart) ? "passed" : "failed");
	endtask

	task automatic drawOperands();
		seed = nextRandom(seed);
		opA = seed[31:16];
		seed = nextRandom(seed);
		opB = seed[31:16];
	endtask

	initial begin
		reset = 1'b1;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;

		startTest();
		checks++;
		assert (!bvalid && !rvalid && !awready && !wready && !arready) else begin
			$display("FAIL %0t: a handshake output is high after reset", $time);
			errors++;
		end
		for (int i = 0; i < 32; i++) begin
			checkRead(readbackAddr(i), 32'h0);
		end
		checkRead(12'h100, 32'h0);  // Instruction memory is write only
		checkRead(12'h400, 32'h0);
		checkRead(12'h880, 32'h0);  // Just past the register window
		reportTest("After reset");

		startTest();
		drawOperands();
		expected = '{opA + opB, opA - opB, opA & opB, opA | opB, opA ^ opB,
			~(opA | opB), ~(opA & opB), ~(opA ^ opB), opA << 1, opA >> 1};
		functs = '{fnAdd, fnSub, fnAnd, fnOr, fnXor, fnNor, fnNand, fnXnor, fnSll, fnSrl};
		prog = {encodeI(opAddi, 0, 1, opA), encodeI(opAddi, 0, 2, opB)};
		for (int i = 0; i < 10; i++) begin
			prog.push_back(encodeR(functs[i], 1, 2, 3 + i));
		end
		prog.push_back(encodeJ(12));
		loadProgram();
		runProgram();
		checkRead(readbackAddr(1), opA);
		checkRead(readbackAddr(2), opB);
		for (int i = 0; i < 10; i++) begin
			checkRead(readbackAddr(3 + i), expected[i]);
		end
		reportTest("R-type operations");

		startTest();
		drawOperands();
		prog = {encodeI(opAddi, 0, 1, 16'h37), encodeI(opAddi, 0, 2, opA),
			encodeI(opAddi, 0, 3, opB), encodeI(opSw, 1, 2, 16'h0), encodeI(opSw, 1, 3, 16'h1),
			encodeI(opLw, 1, 4, 16'h0), encodeI(opLw, 1, 5, 16'h1),
			encodeI(opLw, 1, 6, 16'h10), encodeJ(8)};
		loadProgram();
		runProgram();
		checkRead(readbackAddr(4), opA);
		checkRead(readbackAddr(5), opB);  // Neighbouring address kept apart
		checkRead(readbackAddr(6), 32'h0);  // Never stored
		reportTest("Memory round trip");

		startTest();
		prog = {encodeI(opAddi, 0, 1, 16'd5), encodeI(opAddi, 0, 2, 16'd5),
			encodeI(opAddi, 0, 3, 16'd9), encodeI(opBeq, 1, 2, 16'd2),
			encodeI(opAddi, 0, 4, 16'd1), encodeI(opAddi, 0, 5, 16'd1),
			encodeI(opBne, 1, 3, 16'd1), encodeI(opAddi, 0, 6, 16'd1),
			encodeI(opBeq, 1, 3, 16'd1), encodeI(opAddi, 0, 7, 16'd7),
			encodeI(opBne, 1, 2, 16'd1), encodeI(opAddi, 0, 8, 16'd8), encodeJ(12)};
		loadProgram();
		runProgram();
		expected = '{16'd5, 16'd5, 16'd9, 0, 0, 0, 16'd7, 16'd8, 0, 0};
		for (int i = 0; i < 10; i++) begin
			checkRead(readbackAddr(i + 1), expected[i]);
		end
		reportTest("Branches");

		startTest();
		prog = {encodeI(opAddi, 0, 0, 16'h77), encodeI(opAddi, 0, 1, 16'd3), encodeJ(5),
			encodeI(opAddi, 0, 2, 16'd1), encodeI(opAddi, 0, 3, 16'd1),
			encodeI(opAddi, 0, 4, 16'd4), encodeJ(6)};
		loadProgram();
		repeat (64) @(negedge clk);
		for (int i = 0; i < 5; i++) begin
			checkRead(readbackAddr(i), 32'h0);  // Run bit still clear
		end
		runProgram();
		expected = '{0, 16'd3, 0, 0, 16'd4, 0, 0, 0, 0, 0};
		for (int i = 0; i < 10; i++) begin
			checkRead(readbackAddr(i), expected[i]);
		end
		reportTest("Jump and run control");

		totalErrors = errors + cpuCore_i.cpuCore_properties_i.failCount;
		$display("%0d tests, %0d checks, %0d errors", testsRun, checks, totalErrors);
		if (totalErrors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

// File: cpuCore.f
cpuPkg.sv
hostIf.sv
hostBridge.sv
fetchUnit.sv
controlDecode.sv
regFile.sv
alu.sv
dataMem.sv
cpuCore.sv
cpuCore_properties.sv
tb_cpuCore.sv

// File: Bender.yml
package:
  name: cpuCore

sources:
  - cpuPkg.sv
  - hostIf.sv
  - hostBridge.sv
  - fetchUnit.sv
  - controlDecode.sv
  - regFile.sv
  - alu.sv
  - dataMem.sv
  - cpuCore.sv
  - target: test
    files:
      - cpuCore_properties.sv
      - tb_cpuCore.sv
